/* tb.f */
+incdir+hw
hw/core_pkg.sv
hw/regfile_if.sv
hw/fetch_sequencer.sv
hw/pc_counter.sv
hw/register_file.sv
hw/instr_execute.sv
hw/core_top.sv
bench/core_chk.sv
bench/core_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module core_tb -o core_sim

out=$(./obj_dir/core_sim 2>&1) || true
echo "$out"

if grep -qx "Testbench passed" <<< "$out"; then
  exit 0
else
  exit 1
fi

/* bench/core_tb.sv */
`timescale 1ns/100ps

module core_tb;

  localparam int              N_ENTRIES    = 22;
  localparam int              RESET_CYCLES = 16;
  localparam core_pkg::xlen_t ENTRY        = 64'h0000_0000_8000_0000;

  logic                clk;
  logic                reset;
  core_pkg::xlen_t     entry;
  logic                m_axi_arvalid;
  logic                m_axi_arready;
  core_pkg::xlen_t     m_axi_araddr;
  logic                m_axi_rvalid;
  logic                m_axi_rready;
  core_pkg::xlen_t     m_axi_rdata;
  logic                retire_valid;
  core_pkg::reg_addr_t retire_rd;
  core_pkg::xlen_t     retire_data;

  // Program image with expected retire values, indexed by word offset from entry
  core_pkg::inst_t     prog_word [N_ENTRIES];
  core_pkg::reg_addr_t exp_rd    [N_ENTRIES];
  core_pkg::xlen_t     exp_data  [N_ENTRIES];
  core_pkg::xlen_t     exp_next  [N_ENTRIES];

  logic [31:0] lfsr = 32'hcac1a2c2;

  core_top u_core_top (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;  // 40 ns period
    end
  end

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  // Galois LFSR with taps 32 22 2 1
  function automatic logic next_bit();
    logic lsb;
    lsb  = lfsr[0];
    lfsr = lfsr >> 1;
    if (lsb) lfsr = lfsr ^ 32'h8020_0003;
    return lsb;
  endfunction

  function automatic int rand_delay();
    int d;
    d = 0;
    for (int b = 0; b < 2; b++) d = (d << 1) | int'(next_bit());  // 0 to 3
    return d;
  endfunction

  task automatic compare_rd(input string name, input core_pkg::reg_addr_t got,
                            input core_pkg::reg_addr_t exp);
    if (got !== exp)
      report_failure($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic compare_data(input string name, input core_pkg::xlen_t got,
                              input core_pkg::xlen_t exp);
    if (got !== exp)
      report_failure($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic compare_addr(input string name, input core_pkg::xlen_t got,
                              input core_pkg::xlen_t exp);
    if (got !== exp)
      report_failure($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic set_entry(input int i, input core_pkg::inst_t w, input core_pkg::reg_addr_t rd,
                           input core_pkg::xlen_t data, input int next_idx);
    prog_word[i] = w;
    exp_rd[i]    = rd;
    exp_data[i]  = data;
    exp_next[i]  = ENTRY + core_pkg::xlen_t'(4 * next_idx);
  endtask

  task automatic load_table();
    set_entry(0,  32'h12300093, 5'd1,  64'h123, 1);                    // addi x1,x0,0x123
    set_entry(1,  32'hfff00113, 5'd2,  64'hffff_ffff_ffff_ffff, 2);    // addi x2,x0,-1
    set_entry(2,  32'h0ff0c193, 5'd3,  64'h1dc, 3);                    // xori x3,x1,0xff
    set_entry(3,  32'h4000e213, 5'd4,  64'h523, 4);                    // ori x4,x1,0x400
    set_entry(4,  32'h7f017293, 5'd5,  64'h7f0, 5);                    // andi x5,x2,0x7f0
    set_entry(5,  32'h00308333, 5'd6,  64'h2ff, 6);                    // add x6,x1,x3
    set_entry(6,  32'h403083b3, 5'd7,  64'hffff_ffff_ffff_ff47, 7);    // sub x7,x1,x3
    set_entry(7,  32'h00534433, 5'd8,  64'h50f, 8);                    // xor x8,x6,x5
    set_entry(8,  32'h0050e4b3, 5'd9,  64'h7f3, 9);                    // or x9,x1,x5
    set_entry(9,  32'h00417533, 5'd10, 64'h523, 10);                   // and x10,x2,x4
    set_entry(10, 32'h123455b7, 5'd11, 64'h1234_5000, 11);             // lui x11
    set_entry(11, 32'h80000637, 5'd12, 64'hffff_ffff_8000_0000, 12);   // lui x12, sign bit
    set_entry(12, 32'h00508013, 5'd0,  64'h128, 13);                   // addi x0, value dropped
    set_entry(13, 32'h00b006b3, 5'd13, 64'h1234_5000, 14);             // add x13,x0,x11
    set_entry(14, 32'h00308463, 5'd0,  64'h0, 15);                     // beq not taken
    set_entry(15, 32'h00309463, 5'd0,  64'h0, 17);                     // bne taken
    set_entry(16, 32'h00100713, 5'd14, 64'h1, 17);                     // Skipped
    set_entry(17, 32'h00630463, 5'd0,  64'h0, 19);                     // beq taken
    set_entry(18, 32'h00100793, 5'd15, 64'h1, 19);                     // Skipped
    set_entry(19, 32'h0000068b, 5'd0,  64'h0, 20);                     // custom-0 naming x13, no-op
    set_entry(20, 32'h000687b3, 5'd15, 64'h1234_5000, 21);             // add x15,x13,x0
    set_entry(21, 32'h00109463, 5'd0,  64'h0, 22);                     // bne not taken
  endtask

  // One clock edge with no retire allowed
  task automatic step_no_retire();
    @(posedge clk);
    if (retire_valid) report_failure("retire_valid high while a fetch was pending");
  endtask

  // Waits for a request with no retire in between
  task automatic wait_arvalid();
    do begin
      step_no_retire();
    end while (!m_axi_arvalid);
  endtask

  // Answers one fetch and returns the table index that was served
  task automatic serve_fetch(input core_pkg::xlen_t exp_addr, output int idx);
    core_pkg::xlen_t addr;
    core_pkg::xlen_t offs;
    compare_addr("m_axi_araddr", m_axi_araddr, exp_addr);
    addr = m_axi_araddr;
    offs = addr - ENTRY;
    if (addr < ENTRY || offs >= 4 * N_ENTRIES) report_failure("fetch outside the program");
    idx = int'(offs >> 2);
    repeat (rand_delay()) step_no_retire();
    m_axi_arready <= 1'b1;
    step_no_retire();                          // Address handshake
    m_axi_arready <= 1'b0;
    repeat (rand_delay()) step_no_retire();
    m_axi_rvalid <= 1'b1;
    m_axi_rdata  <= addr[2] ? {prog_word[idx], addr[31:0]} : {addr[31:0], prog_word[idx]};
    do step_no_retire(); while (!m_axi_rready);  // Data handshake edge
    m_axi_rvalid <= 1'b0;
    m_axi_rdata  <= '0;
  endtask

  initial begin
    repeat (RESET_CYCLES + 20 * (N_ENTRIES + 1)) @(posedge clk);
    report_failure("Watchdog expired, the core stopped fetching or retiring");
  end

  initial begin
    core_pkg::xlen_t next_addr;
    int              idx;
    reset         = 1'b1;
    entry         = ENTRY;
    m_axi_arready = 1'b0;
    m_axi_rvalid  = 1'b0;
    m_axi_rdata   = '0;
    load_table();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    next_addr = ENTRY;  // First fetch must come from entry
    idx = 0;
    while (idx < N_ENTRIES) begin
      wait_arvalid();
      serve_fetch(next_addr, idx);
      @(posedge clk);
      if (retire_valid) report_failure("retire_valid one cycle after the data handshake");
      @(posedge clk);
      if (!retire_valid) report_failure("no retire_valid two cycles after the data handshake");
      compare_rd("retire_rd", retire_rd, exp_rd[idx]);
      compare_data("retire_data", retire_data, exp_data[idx]);
      next_addr = exp_next[idx];
      idx = int'((next_addr - ENTRY) >> 2);
    end
    wait_arvalid();
    compare_addr("m_axi_araddr", m_axi_araddr, next_addr);  // Fall-through after the last bne
    $display("Testbench passed");
    $finish;
  end

endmodule

/* bench/core_chk.sv */
`timescale 1ns/100ps

// Bus and retire protocol checks, bound into core_top
module core_chk (
  input logic            clk,
  input logic            reset,
  input logic            m_axi_arvalid,
  input logic            m_axi_arready,
  input core_pkg::xlen_t m_axi_araddr,
  input logic            m_axi_rready,
  input logic            retire_valid
);

  // Address held while the request waits
  a_addr_stable : assert property (@(posedge clk) disable iff (reset)
    m_axi_arvalid && !m_axi_arready |=> m_axi_arvalid && $stable(m_axi_araddr))
    else $error("araddr or arvalid changed before arready");

  // Only one fetch phase at a time
  a_one_phase : assert property (@(posedge clk) disable iff (reset)
    !(m_axi_rready && m_axi_arvalid))
    else $error("rready and arvalid high together");

  a_retire_pulse : assert property (@(posedge clk) disable iff (reset)
    retire_valid |=> !retire_valid)  // Single cycle strobe
    else $error("retire_valid longer than one cycle");

  // Strobes quiet once reset has been seen for a cycle
  a_reset_quiet : assert property (@(posedge clk)
    reset && $past(reset) |-> !m_axi_arvalid && !m_axi_rready && !retire_valid)
    else $error("control output high during reset");

endmodule

bind core_top core_chk u_core_chk (
  .clk           (clk),
  .reset         (reset),
  .m_axi_arvalid (m_axi_arvalid),
  .m_axi_arready (m_axi_arready),
  .m_axi_araddr  (m_axi_araddr),
  .m_axi_rready  (m_axi_rready),
  .retire_valid  (retire_valid)
);

/* hw/core_top.sv */
`timescale 1ns/100ps

// Multi-cycle RV64 integer core
// Instruction fetch over the AXI AR and R channels, one beat per instruction
module core_top (
  input  logic                clk,
  input  logic                reset,
  input  core_pkg::xlen_t     entry,          // First fetch address

  // AXI read address channel
  output logic                m_axi_arvalid,
  input  logic                m_axi_arready,
  output core_pkg::xlen_t     m_axi_araddr,

  // AXI read data channel
  input  logic                m_axi_rvalid,
  output logic                m_axi_rready,
  input  core_pkg::xlen_t     m_axi_rdata,

  // Retire report
  output logic                retire_valid,   // One pulse per instruction
  output core_pkg::reg_addr_t retire_rd,
  output core_pkg::xlen_t     retire_data
);

  logic            ir_load;
  logic            exec_latch;
  logic            branch_taken;
  core_pkg::xlen_t branch_target;

  regfile_if rf_bus ();  // Execute to register file

  fetch_sequencer u_fetch_sequencer (
    .clk        (clk),
    .reset      (reset),
    .arready    (m_axi_arready),
    .rvalid     (m_axi_rvalid),
    .arvalid    (m_axi_arvalid),
    .rready     (m_axi_rready),
    .ir_load    (ir_load),
    .exec_latch (exec_latch),
    .retire     (retire_valid)
  );

  // PC is the fetch address directly
  pc_counter u_pc_counter (
    .clk           (clk),
    .reset         (reset),
    .entry         (entry),
    .retire        (retire_valid),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .pc            (m_axi_araddr)
  );

  register_file u_register_file (
    .clk   (clk),
    .reset (reset),
    .rf    (rf_bus.owner)
  );

  instr_execute u_instr_execute (
    .clk           (clk),
    .reset         (reset),
    .rdata         (m_axi_rdata),
    .pc            (m_axi_araddr),
    .ir_load       (ir_load),
    .exec_latch    (exec_latch),
    .retire        (retire_valid),
    .rf            (rf_bus.user),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .rd            (retire_rd),
    .result        (retire_data)   // Zero for branches and no-ops
  );

endmodule

/* hw/instr_execute.sv */
`timescale 1ns/100ps
`include "core_cfg.svh"

// Instruction register, decode, ALU and branch unit
// Results held from EXECUTE through WRITEBACK
module instr_execute (
  input  logic                clk,
  input  logic                reset,
  input  core_pkg::xlen_t     rdata,          // Read data beat, two instructions wide
  input  core_pkg::xlen_t     pc,             // Address of this instruction
  input  logic                ir_load,
  input  logic                exec_latch,
  input  logic                retire,
  regfile_if.user             rf,
  output logic                branch_taken,
  output core_pkg::xlen_t     branch_target,
  output core_pkg::reg_addr_t rd,             // Destination, 0 if nothing written
  output core_pkg::xlen_t     result          // Write value, 0 if nothing written
);

  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  core_pkg::inst_t     ir;
  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  core_pkg::reg_addr_t rd_f;
  core_pkg::xlen_t     imm_i;
  core_pkg::xlen_t     imm_u;
  core_pkg::xlen_t     imm_b;
  core_pkg::xlen_t     alu_res;
  logic                is_write;
  logic                is_branch;
  logic                br_cond;

  // Pick the 32-bit half that the fetch address points at
  always_ff @(posedge clk) begin
    if (ir_load) begin
      ir <= pc[2] ? rdata[`CORE_XLEN-1:`CORE_ILEN] : rdata[`CORE_ILEN-1:0];
    end
  end

  // Field split
  assign opcode = ir[6:0];
  assign rd_f   = ir[11:7];
  assign funct3 = ir[14:12];
  assign funct7 = ir[31:25];

  // Immediates, all sign extended
  assign imm_i = {{52{ir[31]}}, ir[31:20]};
  assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};
  assign imm_b = {{51{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};

  assign rf.rs1_addr = ir[19:15];
  assign rf.rs2_addr = ir[24:20];

  // ALU and branch compare
  always_comb begin
    alu_res   = '0;
    is_write  = 1'b0;
    is_branch = 1'b0;
    br_cond   = 1'b0;
    case (opcode)
      OPC_OP_IMM: begin
        is_write = 1'b1;
        case (funct3)
          3'b000:  alu_res = rf.rs1_data + imm_i;  // ADDI
          3'b100:  alu_res = rf.rs1_data ^ imm_i;  // XORI
          3'b110:  alu_res = rf.rs1_data | imm_i;  // ORI
          3'b111:  alu_res = rf.rs1_data & imm_i;  // ANDI
          default: is_write = 1'b0;               // Shifts and compares unsupported
        endcase
      end
      OPC_OP: begin
        is_write = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_res = rf.rs1_data + rf.rs2_data;  // ADD
          {7'b0100000, 3'b000}: alu_res = rf.rs1_data - rf.rs2_data;  // SUB
          {7'b0000000, 3'b100}: alu_res = rf.rs1_data ^ rf.rs2_data;  // XOR
          {7'b0000000, 3'b110}: alu_res = rf.rs1_data | rf.rs2_data;  // OR
          {7'b0000000, 3'b111}: alu_res = rf.rs1_data & rf.rs2_data;  // AND
          default:              is_write = 1'b0;
        endcase
      end
      OPC_LUI: begin
        is_write = 1'b1;
        alu_res  = imm_u;
      end
      OPC_BRANCH: begin
        // BEQ and BNE only, other compares fall through as no-ops
        if (funct3 == 3'b000) begin
          is_branch = 1'b1;
          br_cond   = (rf.rs1_data == rf.rs2_data);
        end else if (funct3 == 3'b001) begin
          is_branch = 1'b1;
          br_cond   = (rf.rs1_data != rf.rs2_data);
        end
      end
      default: begin
        // Anything else retires with no effect
      end
    endcase
  end

  // Control flags for writeback and PC
  always_ff @(posedge clk) begin
    if (reset) begin
      rd           <= '0;
      branch_taken <= 1'b0;
    end else if (exec_latch) begin
      rd           <= is_write ? rd_f : '0;
      branch_taken <= is_branch && br_cond;
    end
  end

  // Payload values
  always_ff @(posedge clk) begin
    if (exec_latch) begin
      result        <= is_write ? alu_res : '0;
      branch_target <= pc + imm_b;
    end
  end

  // Writeback during the retire cycle, rd of 0 means no write
  assign rf.wr_en   = retire && (rd != '0);
  assign rf.wr_addr = rd;
  assign rf.wr_data = result;

endmodule

/* hw/register_file.sv */
`timescale 1ns/100ps
`include "core_cfg.svh"

// Integer register file
// Two combinational reads, one write on the clock edge
module register_file (
  input logic      clk,
  input logic      reset,
  regfile_if.owner rf
);

  core_pkg::xlen_t regs [`CORE_NUM_REGS];

  // Write port
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CORE_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.wr_en && (rf.wr_addr != '0)) begin  // x0 is never written
      regs[rf.wr_addr] <= rf.wr_data;
    end
  end

  // Read port 1
  always_comb begin
    if (rf.rs1_addr == '0) begin
      rf.rs1_data = '0;  // Hardwired zero
    end else begin
      rf.rs1_data = regs[rf.rs1_addr];
    end
  end

  // Read port 2
  always_comb begin
    if (rf.rs2_addr == '0) begin
      rf.rs2_data = '0;
    end else begin
      rf.rs2_data = regs[rf.rs2_addr];
    end
  end

endmodule

/* hw/pc_counter.sv */
`timescale 1ns/100ps
`include "core_cfg.svh"

// Program counter
// Starts at entry, moves only when an instruction retires
module pc_counter (
  input  logic            clk,
  input  logic            reset,
  input  core_pkg::xlen_t entry,          // Program entry point
  input  logic            retire,         // Update strobe
  input  logic            branch_taken,   // Retiring branch was taken
  input  core_pkg::xlen_t branch_target,  // PC plus B immediate
  output core_pkg::xlen_t pc              // Fetch address
);

  core_pkg::xlen_t pc_next;

  // Sequential step or redirect
  always_comb begin
    if (branch_taken) begin
      pc_next = branch_target;
    end else begin
      pc_next = pc + core_pkg::xlen_t'(`CORE_PC_STEP);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= entry;  // First fetch from entry
    end else if (retire) begin
      pc <= pc_next;
    end
  end

endmodule

/* hw/fetch_sequencer.sv */
`timescale 1ns/100ps

// One instruction in flight
// Bus strobes are registered copies of the next state, so they sit low in reset
module fetch_sequencer (
  input  logic clk,
  input  logic reset,
  input  logic arready,     // AR channel ready from the bus
  input  logic rvalid,      // R channel valid from the bus
  output logic arvalid,     // AR request, high in FETCH_ADDR
  output logic rready,      // R accept, high in FETCH_DATA
  output logic ir_load,     // Instruction register load on the R handshake
  output logic exec_latch,  // Result register load
  output logic retire       // Register write and PC step
);

  core_pkg::seq_state_t state;
  core_pkg::seq_state_t state_next;

  // Next state, fetch states wait on the bus
  always_comb begin
    state_next = state;
    case (state)
      core_pkg::FETCH_ADDR: begin
        if (arvalid && arready) begin  // Address accepted
          state_next = core_pkg::FETCH_DATA;
        end
      end
      core_pkg::FETCH_DATA: begin
        if (rready && rvalid) begin  // Data beat taken
          state_next = core_pkg::EXECUTE;
        end
      end
      core_pkg::EXECUTE: begin
        state_next = core_pkg::WRITEBACK;  // Single cycle ALU
      end
      core_pkg::WRITEBACK: begin
        state_next = core_pkg::FETCH_ADDR;  // Next fetch with updated PC
      end
      default: begin
        state_next = core_pkg::FETCH_ADDR;
      end
    endcase
  end

  // State and bus-facing strobes
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= core_pkg::FETCH_ADDR;
      arvalid <= 1'b0;
      rready  <= 1'b0;
      retire  <= 1'b0;
    end else begin
      state   <= state_next;
      arvalid <= (state_next == core_pkg::FETCH_ADDR);  // Held until arready
      rready  <= (state_next == core_pkg::FETCH_DATA);
      retire  <= (state_next == core_pkg::WRITEBACK);   // One cycle pulse
    end
  end

  // Internal load pulses
  assign ir_load    = rready && rvalid;               // Same cycle as the R handshake
  assign exec_latch = (state == core_pkg::EXECUTE);

endmodule

/* hw/regfile_if.sv */
`timescale 1ns/100ps

// Register file port bundle, two reads and one write
interface regfile_if;

  core_pkg::reg_addr_t rs1_addr;  // Source 1 index
  core_pkg::reg_addr_t rs2_addr;  // Source 2 index
  core_pkg::xlen_t     rs1_data;  // Source 1 value, combinational
  core_pkg::xlen_t     rs2_data;  // Source 2 value, combinational
  logic                wr_en;     // Write strobe, taken on the clock edge
  core_pkg::reg_addr_t wr_addr;   // Destination index
  core_pkg::xlen_t     wr_data;   // Destination value

  // Execute side
  modport user (
    output rs1_addr,
    output rs2_addr,
    input  rs1_data,
    input  rs2_data,
    output wr_en,
    output wr_addr,
    output wr_data
  );

  // Storage side
  modport owner (
    input  rs1_addr,
    input  rs2_addr,
    output rs1_data,
    output rs2_data,
    input  wr_en,
    input  wr_addr,
    input  wr_data
  );

endinterface

/* hw/core_pkg.sv */
`include "core_cfg.svh"

package core_pkg;

  // Data word and byte address
  typedef logic [`CORE_XLEN-1:0] xlen_t;

  // Raw instruction word
  typedef logic [`CORE_ILEN-1:0] inst_t;

  // Register index, 5 bits for 32 registers
  typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_addr_t;

  // Sequencer steps for one instruction
  // FETCH_ADDR  arvalid out, wait for arready
  // FETCH_DATA  rready out, wait for rvalid
  // EXECUTE     ALU and branch result latched
  // WRITEBACK   register write, PC update, retire strobe
  typedef enum logic [1:0] {
    FETCH_ADDR,
    FETCH_DATA,
    EXECUTE,
    WRITEBACK
  } seq_state_t;

endpackage

/* hw/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Data path and address width
`define CORE_XLEN 64

// One instruction word, half of a bus beat
`define CORE_ILEN 32

// Integer register count, x0 included
`define CORE_NUM_REGS 32

// Byte step from one instruction to the next
`define CORE_PC_STEP 4

`endif
